// ==== all.f ====
+incdir+design
design/isa_pkg.sv
design/ctrl_pkg.sv
design/fetch_if.sv
design/program_loader.sv
design/instr_mem.sv
design/fetch_core.sv
design/fetch_sender.sv
design/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := fetch_tb
FILELIST := all.f
VFLAGS   := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^STATUS: PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/fetch_tb.sv ====
`include "fetch_params.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS       = 6;
    localparam int MAX_TEST_CYCLES = 1200;  // test 1 fills the whole memory
    localparam int TIMEOUT_NS      = (NUM_TESTS * MAX_TEST_CYCLES + 400) * 4;

    logic                       clk = 1'b0;
    logic                       rst_n = 1'b0;
    logic                       load_mode = 1'b1;  // memory empty out of reset
    logic                       upg_wen = 1'b0;
    logic [`UPG_ADDR_WIDTH-1:0] upg_adr = '0;
    isa_pkg::word_t             upg_dat = '0;
    logic                       hold = 1'b0;
    ctrl_pkg::redirect_e        redir_kind = ctrl_pkg::REDIR_NONE;
    isa_pkg::word_t             redir_value = '0;
    logic                       credit_return = 1'b0;
    logic                       dmem_wen;
    logic [`ROM_DEPTH-1:0]      dmem_addr;
    isa_pkg::word_t             dmem_data;
    logic                       fetch_valid;
    isa_pkg::pc_t               fetch_pc;
    isa_pkg::word_t             fetch_instr;

    isa_pkg::word_t ref_mem [1 << `ROM_DEPTH];  // expected imem contents
    isa_pkg::pc_t   got_pc [$];                 // packets since last clear
    isa_pkg::word_t got_instr [$];
    int             pkt_count = 0;
    int             mismatches = 0;
    int             failures = 0;
    logic           auto_return = 1'b1;  // decode frees each slot at once
    logic           ret_due = 1'b0;
    logic           ret_req = 1'b0;

    fetch_top UUT (.*);

    bind fetch_top fetch_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_mode     (load_mode),
        .credit_return (credit_return),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc)
    );

    initial forever #2 clk = ~clk;  // 4 ns period

    // packet monitor samples mid cycle
    always @(negedge clk) begin
        ret_due = auto_return && fetch_valid;
        if (rst_n && fetch_valid) begin
            got_pc.push_back(fetch_pc);
            got_instr.push_back(fetch_instr);
            pkt_count++;
        end
    end

    always @(posedge clk) credit_return <= ret_due || ret_req;  // decode side model

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic check_packet(input int idx, input isa_pkg::pc_t exp_pc, input string msg);
        if (idx >= got_pc.size()) return;  // shortfall already reported
        check_value(got_pc[idx], exp_pc, {msg, " pc"});
        check_value(got_instr[idx], ref_mem[exp_pc[`ROM_DEPTH+1:2]], {msg, " instr"});
    endtask

    task automatic wait_for_packets(input int n);
        int cycles;
        cycles = 0;
        while (got_pc.size() < n && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (got_pc.size() < n) begin
            failures++;
            $display("Error at %0d ns: only %0d of %0d packets arrived",
                     $time, got_pc.size(), n);
        end
    endtask

    task automatic write_upg(input logic [`UPG_ADDR_WIDTH-1:0] adr, input isa_pkg::word_t dat);
        @(posedge clk);
        upg_wen <= 1'b1;
        upg_adr <= adr;
        upg_dat <= dat;
    endtask

    task automatic enter_load();
        @(posedge clk);
        load_mode <= 1'b1;
    endtask

    task automatic leave_load();
        @(posedge clk);
        upg_wen <= 1'b0;
        repeat (2) @(posedge clk);  // let the last imem write land
        got_pc.delete();
        got_instr.delete();
        load_mode <= 1'b0;          // fetch restarts at pc 0
    endtask

    // stop issue, drain, and hand back the pc that comes next
    task automatic quiesce(output isa_pkg::pc_t next_pc);
        @(posedge clk);
        hold <= 1'b1;
        repeat (10) @(posedge clk);
        if (got_pc.size() == 0) begin
            failures++;
            $display("Error at %0d ns: fetch was idle before quiesce", $time);
        end
        next_pc = got_pc[$] + 32'd4;
        got_pc.delete();
        got_instr.delete();
    endtask

    task automatic return_credit();
        @(posedge clk);
        ret_req <= 1'b1;
        @(posedge clk);
        ret_req <= 1'b0;
    endtask

    task automatic reset_then_fetch_sequential();
        @(negedge clk);
        check_value(32'(fetch_valid), 0, "fetch_valid after reset");
        check_value(32'(dmem_wen), 0, "dmem_wen after reset");
        check_value(32'(UUT.fbus.issue), 0, "issue after reset");
        check_value(32'(UUT.pc_reset), 0, "pc_reset after reset");
        check_value(UUT.u_core.pc, 0, "pc after reset");
        enter_load();
        for (int i = 0; i < (1 << `ROM_DEPTH); i++) begin
            ref_mem[i] = $urandom;
            write_upg({1'b0, i[`ROM_DEPTH-1:0]}, ref_mem[i]);
        end
        leave_load();
        wait_for_packets(16);
        for (int i = 0; i < 16; i++) check_packet(i, i * 4, "sequential");
    endtask

    task automatic split_regions();
        int             idx;
        isa_pkg::word_t dat;
        idx = int'($urandom_range(0, 7));  // inside the words fetched below
        dat = $urandom;
        enter_load();
        write_upg({1'b1, idx[`ROM_DEPTH-1:0]}, dat);
        @(posedge clk);
        upg_wen <= 1'b0;
        @(negedge clk);
        check_value(32'(dmem_wen), 1, "dmem_wen one cycle after write");
        check_value(32'(dmem_addr), idx, "dmem_addr without region bit");
        check_value(dmem_data, dat, "dmem_data");
        @(negedge clk);
        check_value(32'(dmem_wen), 0, "dmem_wen single cycle");
        leave_load();
        wait_for_packets(8);
        for (int i = 0; i < 8; i++) check_packet(i, i * 4, "imem after dmem write");
    endtask

    // driver holds the redirect until an issue takes it
    task automatic redirect_fetch(input ctrl_pkg::redirect_e kind, input isa_pkg::word_t value,
                                  input string name);
        isa_pkg::pc_t issue_pc;
        isa_pkg::pc_t target;
        int           waited;
        quiesce(issue_pc);
        if (kind == ctrl_pkg::REDIR_ABS) begin
            target = value;
        end else begin
            target = issue_pc + 32'd4 + (value << 2);
        end
        waited = 0;
        @(posedge clk);
        hold        <= 1'b0;
        redir_kind  <= kind;
        redir_value <= value;
        do begin
            @(negedge clk);
            waited++;
        end while (!UUT.fbus.issue && waited < 50);
        if (!UUT.fbus.issue) begin
            failures++;
            $display("Error at %0d ns: %s redirect never saw an issue", $time, name);
        end
        @(posedge clk);
        redir_kind <= ctrl_pkg::REDIR_NONE;
        wait_for_packets(3);
        check_packet(0, issue_pc, {name, " delay slot"});
        check_packet(1, target, {name, " target"});
        check_packet(2, target + 32'd4, {name, " after target"});
    endtask

    task automatic stall_without_credits();
        isa_pkg::pc_t start_pc;
        int           n_ret;
        quiesce(start_pc);
        auto_return = 1'b0;
        @(posedge clk);
        hold <= 1'b0;
        repeat (30) @(posedge clk);
        check_value(got_pc.size(), `FETCH_CREDITS, "packets with no credit return");
        n_ret = int'($urandom_range(3, 8));
        for (int i = 0; i < n_ret; i++) begin
            repeat ($urandom_range(0, 6)) @(posedge clk);  // random gap
            return_credit();
        end
        wait_for_packets(`FETCH_CREDITS + n_ret);
        repeat (20) @(posedge clk);
        check_value(got_pc.size(), `FETCH_CREDITS + n_ret, "one packet per returned credit");
        for (int i = 0; i < got_pc.size(); i++) check_packet(i, start_pc + i * 4, "resumed");
        @(posedge clk);
        hold <= 1'b1;             // refill with nothing moving
        repeat (`FETCH_CREDITS) return_credit();
        auto_return = 1'b1;
        @(posedge clk);
        hold <= 1'b0;
    endtask

    task automatic hold_and_reload();
        isa_pkg::pc_t next_pc;
        quiesce(next_pc);
        repeat (12) @(posedge clk);
        check_value(got_pc.size(), 0, "no packets while hold is high");
        check_value(UUT.u_core.pc, next_pc, "pc held while hold is high");
        enter_load();
        hold <= 1'b0;             // load_mode blocks issue now
        for (int i = 0; i < 4; i++) begin
            ref_mem[i] = $urandom;
            write_upg({1'b0, i[`ROM_DEPTH-1:0]}, ref_mem[i]);
        end
        leave_load();
        wait_for_packets(6);
        for (int i = 0; i < 6; i++) check_packet(i, i * 4, "after reload");
    endtask

    initial begin
        void'($urandom(32'h8ed01c80));
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        reset_then_fetch_sequential();
        split_regions();
        redirect_fetch(ctrl_pkg::REDIR_OFFSET, isa_pkg::word_t'($urandom_range(1, 100)), "offset");
        redirect_fetch(ctrl_pkg::REDIR_ABS, isa_pkg::word_t'($urandom_range(0, 1023)) << 2, "jump");
        stall_without_credits();
        hold_and_reload();
        $display("errors: %0d mismatches, %0d failures, %0d assertion errors, %0d packets seen",
                 mismatches, failures, UUT.u_checker.assert_fails, pkt_count);
        if (mismatches == 0 && failures == 0 && UUT.u_checker.assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/fetch_checker.sv ====
`include "fetch_params.svh"

module fetch_checker (
    input logic         clk,
    input logic         rst_n,
    input logic         load_mode,
    input logic         credit_return,
    input logic         fetch_valid,
    input isa_pkg::pc_t fetch_pc
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CW = $clog2(`FETCH_CREDITS + 1);

    logic [CW-1:0] credits;       // own count from the ports only
    int            assert_fails = 0;  // failed assertions so far

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CW'(`FETCH_CREDITS);
        end else begin
            credits <= credits + CW'(credit_return) - CW'(fetch_valid);
        end
    end

    send_needs_credit: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_valid |-> credits != '0
    ) else begin
        $error("fetch_valid sent with no credit left");
        assert_fails++;
    end

    quiet_in_load: assert property (
        @(posedge clk) disable iff (!rst_n) load_mode && $past(load_mode) |=> !fetch_valid
    ) else begin
        $error("fetch_valid while load mode is held");
        assert_fails++;
    end

    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_valid |-> fetch_pc[1:0] == 2'b00
    ) else begin
        $error("fetch_pc not word aligned");
        assert_fails++;
    end

endmodule

// ==== design/fetch_top.sv ====
`include "fetch_params.svh"

module fetch_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_mode,
    input  logic                        upg_wen,
    input  logic [`UPG_ADDR_WIDTH-1:0]  upg_adr,
    input  isa_pkg::word_t              upg_dat,
    output logic                        dmem_wen,     // to data memory
    output logic [`ROM_DEPTH-1:0]       dmem_addr,
    output isa_pkg::word_t              dmem_data,
    input  logic                        hold,
    input  ctrl_pkg::redirect_e         redir_kind,
    input  isa_pkg::word_t              redir_value,
    input  logic                        credit_return,
    output logic                        fetch_valid,  // to decode
    output isa_pkg::pc_t                fetch_pc,
    output isa_pkg::word_t              fetch_instr
);

    logic                   imem_we;
    logic [`ROM_DEPTH-1:0]  imem_addr;
    isa_pkg::word_t         imem_data;
    logic                   pc_reset;
    logic                   mem_re;
    logic [`ROM_DEPTH-1:0]  mem_raddr;
    isa_pkg::word_t         mem_rdata;

    fetch_if fbus ();  // core to sender

    program_loader u_loader (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_mode (load_mode),
        .upg_wen   (upg_wen),
        .upg_adr   (upg_adr),
        .upg_dat   (upg_dat),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_wen  (dmem_wen),
        .dmem_addr (dmem_addr),
        .dmem_data (dmem_data),
        .pc_reset  (pc_reset)
    );

    instr_mem u_imem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_data),
        .re    (mem_re),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

    fetch_core u_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_mode   (load_mode),
        .hold        (hold),
        .pc_reset    (pc_reset),
        .redir_kind  (redir_kind),
        .redir_value (redir_value),
        .mem_re      (mem_re),
        .mem_raddr   (mem_raddr),
        .mem_rdata   (mem_rdata),
        .fo          (fbus.core)
    );

    fetch_sender u_sender (
        .clk           (clk),
        .rst_n         (rst_n),
        .fi            (fbus.sender),
        .credit_return (credit_return),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_instr   (fetch_instr)
    );

endmodule

// ==== design/fetch_sender.sv ====
`include "fetch_params.svh"

module fetch_sender (
    input  logic            clk,
    input  logic            rst_n,
    fetch_if.sender         fi,
    input  logic            credit_return,  // decode freed one slot
    output logic            fetch_valid,
    output isa_pkg::pc_t    fetch_pc,
    output isa_pkg::word_t  fetch_instr
);

    localparam int CW = $clog2(`FETCH_CREDITS + 1);

    logic [CW-1:0] credits;   // free slots at decode
    logic [CW-1:0] inflight;  // issued, not yet sent

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits     <= CW'(`FETCH_CREDITS);
            inflight    <= '0;
            fetch_valid <= 1'b0;
        end else begin
            credits     <= credits + CW'(credit_return) - CW'(fetch_valid);
            inflight    <= inflight + CW'(fi.issue) - CW'(fetch_valid);
            fetch_valid <= fi.rd_valid;  // two cycles after issue
        end
    end

    // output register toward decode
    always_ff @(posedge clk) begin
        if (fi.rd_valid) begin
            fetch_pc    <= fi.rd_pkt.pc;
            fetch_instr <= fi.rd_pkt.instr;
        end
    end

    // a credit is spent at issue, so reads in flight count against it
    assign fi.credit_ok = credits > inflight;

endmodule

// ==== design/fetch_core.sv ====
`include "fetch_params.svh"

module fetch_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_mode,    // loader owns memory
    input  logic                   hold,         // stall from hazard logic
    input  logic                   pc_reset,     // end of load, pc back to 0
    input  ctrl_pkg::redirect_e    redir_kind,   // held by driver until issue
    input  isa_pkg::word_t         redir_value,  // word offset or absolute pc
    output logic                   mem_re,
    output logic [`ROM_DEPTH-1:0]  mem_raddr,
    input  isa_pkg::word_t         mem_rdata,
    fetch_if.core                  fo
);

    isa_pkg::pc_t pc;        // next address to read
    isa_pkg::pc_t pc_next;   // pc after this issue
    isa_pkg::pc_t rd_pc_q;   // pc of the read now returning
    logic         issue;
    logic         rd_valid_q;

    // no squash on redirect, the word read this cycle is the delay slot
    assign issue = ~load_mode & ~hold & ~pc_reset & fo.credit_ok;

    always_comb begin
        case (redir_kind)
            ctrl_pkg::REDIR_OFFSET: pc_next = pc + isa_pkg::PC_STEP + (redir_value << 2);
            ctrl_pkg::REDIR_ABS:    pc_next = {redir_value[`ISA_WIDTH-1:2], 2'b00};  // word aligned
            default:                pc_next = pc + isa_pkg::PC_STEP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (pc_reset) begin
                pc <= '0;            // restart after a load
            end else if (issue) begin
                pc <= pc_next;
            end
            rd_valid_q <= issue;     // one cycle read latency
        end
    end

    // pair issued pc with the word coming back
    always_ff @(posedge clk) begin
        if (issue) begin
            rd_pc_q <= fo.rd_pc;
        end
    end

    assign mem_re    = issue;
    assign mem_raddr = isa_pkg::word_index(pc);  // byte address to word index

    assign fo.issue    = issue;
    assign fo.rd_pc    = pc;
    assign fo.rd_valid = rd_valid_q;
    assign fo.rd_pkt   = '{pc: rd_pc_q, instr: mem_rdata};

endmodule

// ==== design/instr_mem.sv ====
`include "fetch_params.svh"

module instr_mem (
    input  logic                   clk,
    input  logic                   we,     // loader write strobe
    input  logic [`ROM_DEPTH-1:0]  waddr,  // word index
    input  isa_pkg::word_t         wdata,
    input  logic                   re,     // fetch read strobe
    input  logic [`ROM_DEPTH-1:0]  raddr,  // word index
    output isa_pkg::word_t         rdata   // valid the cycle after re
);

    localparam int WORDS = 1 << `ROM_DEPTH;

    isa_pkg::word_t mem [WORDS];  // program storage

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, holds last word while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== design/program_loader.sv ====
`include "fetch_params.svh"

module program_loader (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_mode,   // high while a program is loaded
    input  logic                        upg_wen,     // upgrade port write strobe
    input  logic [`UPG_ADDR_WIDTH-1:0]  upg_adr,     // word address, top bit is region
    input  isa_pkg::word_t              upg_dat,     // upgrade word
    output logic                        imem_we,
    output logic [`ROM_DEPTH-1:0]       imem_addr,
    output isa_pkg::word_t              imem_data,
    output logic                        dmem_wen,
    output logic [`ROM_DEPTH-1:0]       dmem_addr,
    output isa_pkg::word_t              dmem_data,
    output logic                        pc_reset     // one cycle when load ends
);

    logic                        wen_q;   // registered strobe, load mode only
    logic [`UPG_ADDR_WIDTH-1:0]  adr_q;
    isa_pkg::word_t              dat_q;
    logic                        load_q;  // load_mode last cycle
    ctrl_pkg::region_e           region;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wen_q  <= 1'b0;
            load_q <= 1'b0;
        end else begin
            wen_q  <= upg_wen & load_mode;  // drop writes outside load mode
            load_q <= load_mode;
        end
    end

    always_ff @(posedge clk) begin
        if (upg_wen) begin
            adr_q <= upg_adr;
            dat_q <= upg_dat;
        end
    end

    assign region = ctrl_pkg::region_e'(adr_q[`UPG_ADDR_WIDTH-1]);  // top bit picks target

    assign imem_we   = wen_q & (region == ctrl_pkg::REGION_IMEM);
    assign imem_addr = adr_q[`ROM_DEPTH-1:0];
    assign imem_data = dat_q;

    assign dmem_wen  = wen_q & (region == ctrl_pkg::REGION_DMEM);
    assign dmem_addr = adr_q[`ROM_DEPTH-1:0];  // region bit stripped
    assign dmem_data = dat_q;

    // falling edge of load_mode, kept combinational so the core
    // cannot issue from a stale pc in the first cycle after loading
    assign pc_reset = load_q & ~load_mode;

endmodule

// ==== design/fetch_if.sv ====
interface fetch_if;

    logic                 issue;      // read started this cycle
    isa_pkg::pc_t         rd_pc;      // pc of that read
    logic                 credit_ok;  // room left downstream
    logic                 rd_valid;   // memory word returned
    isa_pkg::fetch_pkt_t  rd_pkt;     // pc and word of the return

    modport core (
        output issue,
        output rd_pc,
        output rd_valid,
        output rd_pkt,
        input  credit_ok
    );

    modport sender (
        input  issue,
        input  rd_pc,
        input  rd_valid,
        input  rd_pkt,
        output credit_ok
    );

endinterface

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

    // next pc selection on an issue
    typedef enum logic [1:0] {
        REDIR_NONE   = 2'b00,  // pc + 4
        REDIR_OFFSET = 2'b01,  // pc + 4 + 4 * value
        REDIR_ABS    = 2'b10   // pc = value
    } redirect_e;

    // upgrade address space, split by the top address bit
    typedef enum logic {
        REGION_IMEM = 1'b0,  // lower half, instruction words
        REGION_DMEM = 1'b1   // upper half, data words
    } region_e;

endpackage

// ==== design/isa_pkg.sv ====
`include "fetch_params.svh"

package isa_pkg;

    // one instruction or data word
    typedef logic [`ISA_WIDTH-1:0] word_t;

    // byte address, low two bits stay zero
    typedef logic [`ISA_WIDTH-1:0] pc_t;

    // one fetched instruction with its address
    typedef struct packed {
        pc_t   pc;     // address of instr
        word_t instr;  // word read at pc
    } fetch_pkt_t;

    // sequential step in bytes
    localparam pc_t PC_STEP = `ISA_WIDTH'(4);

    // byte address to instruction memory word index
    function automatic logic [`ROM_DEPTH-1:0] word_index(pc_t addr);
        return addr[`ROM_DEPTH+1:2];
    endfunction

endpackage

// ==== design/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// instruction word and byte address width
`define ISA_WIDTH 32

// log2 of instruction memory words
`define ROM_DEPTH 10

// upgrade address, top bit picks imem or dmem
`define UPG_ADDR_WIDTH (`ROM_DEPTH + 1)

// decode side buffer depth, also credits out of reset
`define FETCH_CREDITS 4

`endif
